//--- Bender.yml
package:
  name: des_block

sources:
  - files:
      - logic/des_pkg.sv
      - logic/des_cipher.sv
      - logic/block_ram.sv
      - logic/block_sequencer.sv
      - logic/pipe_port.sv
      - logic/des_block_top.sv
  - target: test
    files:
      - test/des_block_asserts.sv
      - test/des_block_tb.sv

//--- des_block.f
logic/des_pkg.sv
logic/des_cipher.sv
logic/block_ram.sv
logic/block_sequencer.sv
logic/pipe_port.sv
logic/des_block_top.sv
test/des_block_asserts.sv
test/des_block_tb.sv

//--- logic/block_ram.sv
`timescale 1ns/10ps

module block_ram #(
	parameter int ram_depth = 512,
	localparam int addr_w = $clog2(ram_depth)
) (
	input  logic              dcm_clk,
	input  logic [addr_w-1:0] wr_addr,
	input  logic              wr_en,
	input  des_pkg::block_t   wr_data,
	input  logic [addr_w-1:0] rd_addr,
	output des_pkg::block_t   rd_data
);

	des_pkg::block_t mem [ram_depth];

	// Write port
	always_ff @(posedge dcm_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read, data one cycle after the address
	always_ff @(posedge dcm_clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- logic/block_sequencer.sv
`timescale 1ns/10ps

module block_sequencer #(
	parameter int ram_depth = 512,
	localparam int addr_w = $clog2(ram_depth)
) (
	input  logic              dcm_clk,
	input  logic              ram_reset,
	input  logic              start,
	output logic              done,
	output logic [addr_w-1:0] in_addr,
	input  des_pkg::block_t   in_data,
	output des_pkg::round_t   round_sel,
	output des_pkg::block_t   cipher_in,
	input  des_pkg::block_t   cipher_out,
	output logic [addr_w-1:0] out_addr,
	output logic              out_en,
	output des_pkg::block_t   out_data
);

	des_pkg::seq_state_t state;

	// ----------------------------------------
	// Word loop
	// ----------------------------------------
	// 20 cycles per word, done one cycle after finish
	always_ff @(posedge dcm_clk) begin
		if (ram_reset) begin
			state     <= des_pkg::idle;
			done      <= 1'b0;
			in_addr   <= '0;
			out_addr  <= '0;
			round_sel <= '1;
		end else begin
			done <= 1'b0;
			case (state)
				des_pkg::idle: begin
					if (start) begin
						in_addr  <= '0;
						out_addr <= '0;
						state    <= des_pkg::load_addr;
					end
				end
				des_pkg::load_addr: begin
					// RAM samples the old address on this edge
					in_addr <= addr_w'(des_pkg::wrap_next(in_addr, ram_depth));
					state   <= des_pkg::load_data;
				end
				des_pkg::load_data: begin
					round_sel <= '0;
					state     <= des_pkg::run_rounds;
				end
				des_pkg::run_rounds: begin
					// round_sel parks at 15 so the cipher holds its result
					if (round_sel == 4'd15) begin
						state <= des_pkg::save_word;
					end else begin
						round_sel <= round_sel + 1'b1;
					end
				end
				des_pkg::save_word: begin
					state <= des_pkg::next_word;
				end
				des_pkg::next_word: begin
					out_addr <= addr_w'(des_pkg::wrap_next(out_addr, ram_depth));
					// Read address back at zero means the whole RAM is done
					if (in_addr == '0) begin
						state <= des_pkg::finish;
					end else begin
						state <= des_pkg::load_addr;
					end
				end
				des_pkg::finish: begin
					done  <= 1'b1;
					state <= des_pkg::idle;
				end
				default: begin
					state <= des_pkg::idle;
				end
			endcase
		end
	end

	// Input word captured while the RAM output is still valid
	always_ff @(posedge dcm_clk) begin
		if (state == des_pkg::load_data) begin
			cipher_in <= in_data;
		end
	end

	// Output RAM captures the cipher result at the end of save_word
	assign out_en   = (state == des_pkg::save_word);
	assign out_data = cipher_out;

endmodule

//--- logic/des_block_top.sv
`timescale 1ns/10ps

module des_block_top #(
	parameter int ram_depth = 512
) (
	input  logic            dcm_clk,
	input  logic            ram_reset,
	input  des_pkg::key_t   key,
	input  logic            decrypt,
	input  logic            start,
	output logic            done,
	input  logic            pipe_in_start,
	input  logic            pipe_in_valid,
	input  des_pkg::block_t pipe_in_data,
	output logic            pipe_in_read,
	input  logic            pipe_out_start,
	input  logic            pipe_out_full,
	output logic            pipe_out_write,
	output des_pkg::block_t pipe_out_data
);

	localparam int addr_w = $clog2(ram_depth);

	logic [addr_w-1:0] in_wr_addr;
	logic [addr_w-1:0] in_rd_addr;
	des_pkg::block_t   in_rd_data;
	logic [addr_w-1:0] out_wr_addr;
	logic              out_wr_en;
	des_pkg::block_t   out_wr_data;
	logic [addr_w-1:0] out_rd_addr;
	des_pkg::round_t   round_sel;
	des_pkg::block_t   cipher_in;
	des_pkg::block_t   cipher_out;

	// ----------------------------------------
	// Host side
	// ----------------------------------------
	pipe_port #(.ram_depth(ram_depth)) pipe_port_i (
		.dcm_clk        (dcm_clk),
		.ram_reset      (ram_reset),
		.pipe_in_start  (pipe_in_start),
		.pipe_in_valid  (pipe_in_valid),
		.pipe_out_start (pipe_out_start),
		.pipe_out_full  (pipe_out_full),
		.pipe_in_read   (pipe_in_read),
		.in_wr_addr     (in_wr_addr),
		.pipe_out_write (pipe_out_write),
		.out_rd_addr    (out_rd_addr)
	);

	// Plaintext or ciphertext from the host
	block_ram #(.ram_depth(ram_depth)) in_ram (
		.dcm_clk (dcm_clk),
		.wr_addr (in_wr_addr),
		.wr_en   (pipe_in_valid),
		.wr_data (pipe_in_data),
		.rd_addr (in_rd_addr),
		.rd_data (in_rd_data)
	);

	// Results waiting to be drained
	block_ram #(.ram_depth(ram_depth)) out_ram (
		.dcm_clk (dcm_clk),
		.wr_addr (out_wr_addr),
		.wr_en   (out_wr_en),
		.wr_data (out_wr_data),
		.rd_addr (out_rd_addr),
		.rd_data (pipe_out_data)
	);

	// ----------------------------------------
	// Cipher side
	// ----------------------------------------
	block_sequencer #(.ram_depth(ram_depth)) block_sequencer_i (
		.dcm_clk    (dcm_clk),
		.ram_reset  (ram_reset),
		.start      (start),
		.done       (done),
		.in_addr    (in_rd_addr),
		.in_data    (in_rd_data),
		.round_sel  (round_sel),
		.cipher_in  (cipher_in),
		.cipher_out (cipher_out),
		.out_addr   (out_wr_addr),
		.out_en     (out_wr_en),
		.out_data   (out_wr_data)
	);

	des_cipher des_cipher_i (
		.dcm_clk   (dcm_clk),
		.round_sel (round_sel),
		.decrypt   (decrypt),
		.key       (key),
		.data_in   (cipher_in),
		.data_out  (cipher_out)
	);

endmodule

//--- logic/des_cipher.sv
`timescale 1ns/10ps

module des_cipher (
	input  logic            dcm_clk,
	input  des_pkg::round_t round_sel,
	input  logic            decrypt,
	input  des_pkg::key_t   key,
	input  des_pkg::block_t data_in,
	output des_pkg::block_t data_out
);

	// ----------------------------------------
	// Permutation tables
	// ----------------------------------------
	// Standard DES numbering, bit 1 is the MSB of each vector
	localparam int ip_tab [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2,
		60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6,
		64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1,
		59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5,
		63, 55, 47, 39, 31, 23, 15, 7
	};
	localparam int fp_tab [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32,
		39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30,
		37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28,
		35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26,
		33, 1, 41, 9, 49, 17, 57, 25
	};
	localparam int e_tab [48] = '{
		32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
		8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
	};
	localparam int p_tab [32] = '{
		16, 7, 20, 21, 29, 12, 28, 17,
		1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9,
		19, 13, 30, 6, 22, 11, 4, 25
	};
	// PC-1 never selects bits 8, 16 .. 64, which drops the key parity
	localparam int pc1_tab [56] = '{
		57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
	};
	localparam int pc2_tab [48] = '{
		14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
		23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};
	// Total left rotation of C and D after rounds 1 to 16
	localparam int shift_tot [16] = '{1, 2, 4, 6, 8, 10, 12, 14, 15, 17, 19, 21, 23, 25, 27, 28};

	logic [31:0]     l_reg;
	logic [31:0]     r_reg;
	logic            rounds_on;
	des_pkg::block_t ip_out;
	logic [31:0]     l_cur;
	logic [31:0]     r_cur;
	logic [55:0]     cd_perm;
	logic [4:0]      rot_n;
	logic [55:0]     cd_rot;
	logic [47:0]     subkey;
	logic [47:0]     e_out;
	logic [47:0]     s_in;
	logic [31:0]     s_out;
	logic [31:0]     f_out;
	des_pkg::block_t pre_out;

	function automatic logic [27:0] rot28(input logic [27:0] half, input logic [4:0] n);
		logic [55:0] twice;
		twice = {half, half} << n;
		return twice[55:28];
	endfunction

	// ----------------------------------------
	// Key schedule
	// ----------------------------------------
	// Subkey straight from the round number, decrypt walks the schedule backwards
	always_comb begin
		for (int i = 0; i < 56; i++) begin
			cd_perm[55 - i] = key[64 - pc1_tab[i]];
		end
		rot_n = decrypt ? 5'(shift_tot[15 - round_sel]) : 5'(shift_tot[round_sel]);
		cd_rot = {rot28(cd_perm[55:28], rot_n), rot28(cd_perm[27:0], rot_n)};
		for (int i = 0; i < 48; i++) begin
			subkey[47 - i] = cd_rot[56 - pc2_tab[i]];
		end
	end

	// ----------------------------------------
	// Round function
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < 64; i++) begin
			ip_out[63 - i] = data_in[64 - ip_tab[i]];
		end
		// Round 0 starts from the new block
		l_cur = (round_sel == '0) ? ip_out[63:32] : l_reg;
		r_cur = (round_sel == '0) ? ip_out[31:0] : r_reg;
		for (int i = 0; i < 48; i++) begin
			e_out[47 - i] = r_cur[32 - e_tab[i]];
		end
		s_in = e_out ^ subkey;
		for (int b = 0; b < 8; b++) begin
			s_out[31 - 4 * b -: 4] = des_pkg::sbox_lookup(3'(b), s_in[47 - 6 * b -: 6]);
		end
		for (int i = 0; i < 32; i++) begin
			f_out[31 - i] = s_out[32 - p_tab[i]];
		end
	end

	// Registers stop after round 15 and hold the result until the next round 0
	always_ff @(posedge dcm_clk) begin
		if (round_sel == '0 || rounds_on) begin
			l_reg     <= r_cur;
			r_reg     <= l_cur ^ f_out;
			rounds_on <= (round_sel != 4'd15);
		end
	end

	// Final permutation of the swapped halves
	assign pre_out = {r_reg, l_reg};

	always_comb begin
		for (int i = 0; i < 64; i++) begin
			data_out[63 - i] = pre_out[64 - fp_tab[i]];
		end
	end

endmodule

//--- logic/des_pkg.sv
package des_pkg;

	// ----------------------------------------
	// Widths and data types
	// ----------------------------------------
	localparam int block_w = 64;
	localparam int key_w   = 64;
	localparam int round_w = 4;

	typedef logic [block_w-1:0] block_t;
	typedef logic [key_w-1:0]   key_t;
	typedef logic [round_w-1:0] round_t;

	// Sequencer states, one word per pass through load_addr..next_word
	typedef enum logic [2:0] {
		idle,
		load_addr,
		load_data,
		run_rounds,
		save_word,
		next_word,
		finish
	} seq_state_t;

	// ----------------------------------------
	// S-boxes
	// ----------------------------------------
	// Each entry holds one box, row 0 column 0 in the top nibble
	localparam logic [255:0] sbox_table [8] = '{
		256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
		256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
		256'hA09E63F51DC7B428_D70934A6285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
		256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
		256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
		256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
		256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
		256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
	};

	// Outer bits pick the row, inner four bits pick the column
	function automatic logic [3:0] sbox_lookup(
		input logic [2:0] box,
		input logic [5:0] six
	);
		logic [5:0]   idx;
		logic [255:0] box_bits;
		idx      = {six[5], six[0], six[4:1]};
		box_bits = sbox_table[box];
		return box_bits[255 - 4 * idx -: 4];
	endfunction

	// ----------------------------------------
	// Address helper
	// ----------------------------------------
	// Next RAM address, back to zero after the last word
	function automatic int unsigned wrap_next(
		input int unsigned addr,
		input int unsigned depth
	);
		return (addr + 1 == depth) ? 0 : addr + 1;
	endfunction

endpackage

//--- logic/pipe_port.sv
`timescale 1ns/10ps

module pipe_port #(
	parameter int ram_depth = 512,
	localparam int addr_w = $clog2(ram_depth)
) (
	input  logic              dcm_clk,
	input  logic              ram_reset,
	input  logic              pipe_in_start,
	input  logic              pipe_in_valid,
	input  logic              pipe_out_start,
	input  logic              pipe_out_full,
	output logic              pipe_in_read,
	output logic [addr_w-1:0] in_wr_addr,
	output logic              pipe_out_write,
	output logic [addr_w-1:0] out_rd_addr
);

	logic started;
	logic out_go;

	// Read the output RAM only when the host has room
	assign out_go = started && !pipe_out_full;

	always_ff @(posedge dcm_clk) begin
		if (ram_reset) begin
			pipe_in_read   <= 1'b0;
			started        <= 1'b0;
			in_wr_addr     <= '0;
			out_rd_addr    <= '0;
			pipe_out_write <= 1'b0;
		end else begin
			if (pipe_in_start) begin
				pipe_in_read <= 1'b1;
			end
			if (pipe_out_start) begin
				started <= 1'b1;
			end
			if (pipe_in_valid) begin
				in_wr_addr <= addr_w'(des_pkg::wrap_next(in_wr_addr, ram_depth));
			end
			if (out_go) begin
				out_rd_addr <= addr_w'(des_pkg::wrap_next(out_rd_addr, ram_depth));
			end
			// Lines up with the registered RAM read data
			pipe_out_write <= out_go;
		end
	end

endmodule

//--- test/des_block_asserts.sv
`timescale 1ns/10ps

module des_block_asserts (
	input logic                dcm_clk,
	input logic                ram_reset,
	input des_pkg::seq_state_t state,
	input logic                done,
	input des_pkg::round_t     round_sel,
	input logic                out_en,
	input logic                pipe_out_full,
	input logic                pipe_out_write
);

	// Failed assertions in this instance
	int fail_count = 0;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	done_pulse: assert property (@(posedge dcm_clk) disable iff (ram_reset)
		done |=> !done)
	else begin
		fail_count++;
		$error("done stayed high for more than one cycle");
	end

	// One round per cycle until round 15 parks the cipher
	round_step: assert property (@(posedge dcm_clk) disable iff (ram_reset)
		(state == des_pkg::run_rounds && round_sel != 4'd15)
			|=> round_sel == des_pkg::round_t'($past(round_sel) + 1'b1))
	else begin
		fail_count++;
		$error("round_sel did not advance by one in run_rounds");
	end

	// A write only ever follows the last round of a word
	save_only: assert property (@(posedge dcm_clk) disable iff (ram_reset)
		out_en |-> $past(state) == des_pkg::run_rounds && $past(round_sel) == 4'd15)
	else begin
		fail_count++;
		$error("output RAM written outside save_word");
	end

	// ----------------------------------------
	// Pipe port
	// ----------------------------------------
	full_holds: assert property (@(posedge dcm_clk) disable iff (ram_reset)
		$past(pipe_out_full) |-> !pipe_out_write)
	else begin
		fail_count++;
		$error("pipe_out_write high the cycle after pipe_out_full");
	end

endmodule

// Each instance sees constants on the signals of the other block
bind block_sequencer des_block_asserts seq_chk_i (
	.dcm_clk        (dcm_clk),
	.ram_reset      (ram_reset),
	.state          (state),
	.done           (done),
	.round_sel      (round_sel),
	.out_en         (out_en),
	.pipe_out_full  (1'b0),
	.pipe_out_write (1'b0)
);

bind pipe_port des_block_asserts pipe_chk_i (
	.dcm_clk        (dcm_clk),
	.ram_reset      (ram_reset),
	.state          (des_pkg::idle),
	.done           (1'b0),
	.round_sel      ('0),
	.out_en         (1'b0),
	.pipe_out_full  (pipe_out_full),
	.pipe_out_write (pipe_out_write)
);

//--- test/des_block_tb.sv
`timescale 1ns/10ps

module des_block_tb;

	localparam int depth      = 16;
	localparam int run_cycles = 20 * depth + 2;
	// Four cipher passes with load and drain plus reset and slack
	localparam int watchdog_cycles = 4 * (20 * depth + 40) + 200;

	localparam des_pkg::key_t   kat_key    = 64'h133457799BBCDFF1;
	localparam des_pkg::block_t kat_plain  = 64'h0123456789ABCDEF;
	localparam des_pkg::block_t kat_cipher = 64'h85E813540F0AB405;

	logic            dcm_clk;
	logic            ram_reset;
	des_pkg::key_t   key;
	logic            decrypt;
	logic            start;
	logic            done;
	logic            pipe_in_start;
	logic            pipe_in_valid;
	des_pkg::block_t pipe_in_data;
	logic            pipe_in_read;
	logic            pipe_out_start;
	logic            pipe_out_full;
	logic            pipe_out_write;
	des_pkg::block_t pipe_out_data;

	integer          seed;
	int              cycle = 0;
	int              runs = 0;
	int              done_count = 0;
	int              done_cycle = 0;
	des_pkg::key_t   rt_key;
	des_pkg::block_t in_mem [depth];
	des_pkg::block_t expect_q [$];
	des_pkg::block_t got_q [$];
	des_pkg::block_t plain_q [$];
	des_pkg::block_t cipher_q [$];

	des_block_top #(.ram_depth(depth)) des_block_top_i (
		.dcm_clk        (dcm_clk),
		.ram_reset      (ram_reset),
		.key            (key),
		.decrypt        (decrypt),
		.start          (start),
		.done           (done),
		.pipe_in_start  (pipe_in_start),
		.pipe_in_valid  (pipe_in_valid),
		.pipe_in_data   (pipe_in_data),
		.pipe_in_read   (pipe_in_read),
		.pipe_out_start (pipe_out_start),
		.pipe_out_full  (pipe_out_full),
		.pipe_out_write (pipe_out_write),
		.pipe_out_data  (pipe_out_data)
	);

	initial begin
		dcm_clk = 1'b0;
		forever #5 dcm_clk = ~dcm_clk;
	end

	always @(posedge dcm_clk) begin
		cycle <= cycle + 1;
	end

	// ----------------------------------------
	// Error handling and compare tasks
	// ----------------------------------------
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	function automatic int assert_failures();
		return des_block_top_i.block_sequencer_i.seq_chk_i.fail_count
			+ des_block_top_i.pipe_port_i.pipe_chk_i.fail_count;
	endfunction

	task automatic check_block(input string name, input des_pkg::block_t got,
			input des_pkg::block_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_done(input string name, input int got, input int exp);
		if (got != exp) begin
			report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	// ----------------------------------------
	// Monitors and watchdog
	// ----------------------------------------
	// Outputs sampled mid cycle away from the driving edge
	always @(negedge dcm_clk) begin
		if (!ram_reset) begin
			if (pipe_out_write) begin
				got_q.push_back(pipe_out_data);
			end
			if (done) begin
				done_count++;
				done_cycle = cycle;
			end
		end
		if (assert_failures() != 0) begin
			report_failure("A bound assertion on the sequencer or the pipe port failed");
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge dcm_clk);
		report_failure("Watchdog timeout, the tests did not finish in time");
	end

	// ----------------------------------------
	// Stimulus tasks
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge dcm_clk);
		#1;
	endtask

	task automatic random_block(output des_pkg::block_t w);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		w  = {hi, lo};
	endtask

	task automatic prepare_constant(input des_pkg::block_t load_w, input des_pkg::block_t exp_w);
		expect_q.delete();
		for (int i = 0; i < depth; i++) begin
			in_mem[i] = load_w;
			expect_q.push_back(exp_w);
		end
	endtask

	// One word per cycle until the input address wraps back to zero
	task automatic load_words();
		for (int i = 0; i < depth; i++) begin
			pipe_in_valid = 1'b1;
			pipe_in_data  = in_mem[i];
			next_cycle();
		end
		pipe_in_valid = 1'b0;
		pipe_in_data  = '0;
	endtask

	// Start a pass, poke start again mid run, then wait for done
	task automatic run_block(input logic dec, input des_pkg::key_t k);
		int start_cycle;
		key     = k;
		decrypt = dec;
		runs++;
		start       = 1'b1;
		start_cycle = cycle;
		next_cycle();
		start = 1'b0;
		repeat (40) next_cycle();
		start = 1'b1;
		next_cycle();
		start = 1'b0;
		while (done_count < runs) begin
			next_cycle();
		end
		check_done("done latency", done_cycle - start_cycle, run_cycles);
		repeat (3) next_cycle();
		check_done("done pulses", done_count, runs);
	endtask

	// Issue depth reads with optional random back-pressure
	task automatic drain_words(input bit throttle);
		int          issued;
		int          waited;
		logic [31:0] r;
		got_q.delete();
		issued = 0;
		while (issued < depth) begin
			r = $random(seed);
			pipe_out_full = throttle && r[0];
			if (!pipe_out_full) begin
				issued++;
			end
			next_cycle();
		end
		pipe_out_full = 1'b1;
		waited = 0;
		while (got_q.size() < depth && waited < 10) begin
			next_cycle();
			waited++;
		end
		repeat (3) next_cycle();
		if (got_q.size() != depth) begin
			report_failure($sformatf("Mismatch pipe_out_write count: got %h expected %h",
				got_q.size(), depth));
		end
	endtask

	task automatic check_drain();
		for (int i = 0; i < depth; i++) begin
			check_block($sformatf("pipe_out_data[%0d]", i), got_q[i], expect_q[i]);
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		des_pkg::block_t w;
		seed           = 32'hd3fe;
		ram_reset      = 1'b1;
		key            = '0;
		decrypt        = 1'b0;
		start          = 1'b0;
		pipe_in_start  = 1'b0;
		pipe_in_valid  = 1'b0;
		pipe_in_data   = '0;
		pipe_out_start = 1'b0;
		pipe_out_full  = 1'b1;
		repeat (3) @(posedge dcm_clk);
		#1;
		ram_reset = 1'b0;
		if (done !== 1'b0 || pipe_in_read !== 1'b0 || pipe_out_write !== 1'b0) begin
			report_failure("Outputs not low after reset");
		end

		pipe_in_start  = 1'b1;
		pipe_out_start = 1'b1;
		next_cycle();
		pipe_in_start  = 1'b0;
		pipe_out_start = 1'b0;
		if (pipe_in_read !== 1'b1) begin
			report_failure("pipe_in_read did not rise after pipe_in_start");
		end

		// Known answer in both directions
		prepare_constant(kat_plain, kat_cipher);
		load_words();
		run_block(1'b0, kat_key);
		drain_words(1'b0);
		check_drain();

		prepare_constant(kat_cipher, kat_plain);
		load_words();
		run_block(1'b1, kat_key);
		drain_words(1'b0);
		check_drain();

		// Round trip with random data and key
		random_block(rt_key);
		plain_q.delete();
		for (int i = 0; i < depth; i++) begin
			random_block(w);
			in_mem[i] = w;
			plain_q.push_back(w);
		end
		load_words();
		run_block(1'b0, rt_key);
		drain_words(1'b0);
		cipher_q = got_q;

		// Decrypted words come back under back-pressure in address order
		for (int i = 0; i < depth; i++) begin
			in_mem[i] = cipher_q[i];
		end
		load_words();
		run_block(1'b1, rt_key);
		expect_q = plain_q;
		drain_words(1'b1);
		check_drain();

		check_done("done pulses", done_count, runs);
		if (pipe_in_read !== 1'b1) begin
			report_failure("pipe_in_read dropped before reset");
		end
		if (assert_failures() != 0) begin
			report_failure("A bound assertion failed during the run");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule
